// ==== design/node_defs.svh ====
`ifndef NODE_DEFS_SVH
`define NODE_DEFS_SVH

// Node address widths
`define NODE_ROW_W    4
`define NODE_COL_W    4

// Core I/O counts and index width
`define NODE_INPUTS   8
`define NODE_OUTPUTS  8
`define NODE_IDX_W    3

// Fan-out table size
`define FANOUT_DEPTH  32
`define FANOUT_AW     5

// Full message word
`define MSG_W         21

`endif

// ==== design/node_msg_pkg.sv ====
`include "node_defs.svh"

package node_msg_pkg;

// Mesh message commands
typedef enum logic [1:0] {
      CMD_LOAD_INSTR = 2'd0
    , CMD_OUTPUT     = 2'd1
    , CMD_SIG_STATE  = 2'd2
    , CMD_CONTROL    = 2'd3
} node_command_t;

// Outbound route directions
typedef enum logic [1:0] {
      DIR_NORTH = 2'd0
    , DIR_EAST  = 2'd1
    , DIR_SOUTH = 2'd2
    , DIR_WEST  = 2'd3
} node_dir_t;

// Destination node and command
typedef struct packed {
    logic [`NODE_ROW_W-1:0] row;
    logic [`NODE_COL_W-1:0] column;
    node_command_t          command;
} node_header_t;

// Generic view, payload left undecoded
typedef struct packed {
    node_header_t                             header;
    logic [`MSG_W-$bits(node_header_t)-1:0]   payload;
} node_msg_raw_t;

// Signal state update view
typedef struct packed {
    node_header_t           header;
    logic [5:0]             pad;
    logic [`NODE_IDX_W-1:0] target_index;
    logic                   target_is_seq;
    logic                   state;
} node_msg_sig_state_t;

typedef union packed {
    node_msg_raw_t       raw;
    node_msg_sig_state_t sig_state;
} node_msg_t;

endpackage : node_msg_pkg

// ==== design/node_map_pkg.sv ====
`include "node_defs.svh"

package node_map_pkg;

// One fan-out target of an output
typedef struct packed {
    logic [`NODE_ROW_W-1:0] tgt_row;
    logic [`NODE_COL_W-1:0] tgt_col;
    logic [`NODE_IDX_W-1:0] tgt_idx;
    logic                   tgt_is_seq;
} fanout_entry_t;

// Changed output and its new value
typedef struct packed {
    logic [`NODE_IDX_W-1:0] index;
    logic                   state;
} change_req_t;

endpackage : node_map_pkg

// ==== design/node_ifs.sv ====
// Detector to table, one change per transfer
interface change_if;
import node_map_pkg::*;

change_req_t req;
logic        valid;
// Change queue has no room
logic        full;

modport producer (output req, output valid, input full);
modport consumer (input req, input valid, output full);

endinterface : change_if

// Table walker to message builder
interface fanout_if;
import node_map_pkg::*;

fanout_entry_t entry;
logic          state;
// Strobe, one cycle per table entry
logic          valid;
// Builder FIFO cannot take more
logic          stall;

modport source (output entry, output state, output valid, input stall);
modport sink   (input entry, input state, input valid, output stall);

endinterface : fanout_if

// ==== design/sync_fifo.sv ====
module sync_fifo #(
      parameter int DEPTH = 2
    , parameter int WIDTH = 8
) (
      input  logic             clk_i
    , input  logic             rst_n_i
    , input  logic [WIDTH-1:0] wr_data_i
    , input  logic             push_i
    , output logic [WIDTH-1:0] rd_data_o
    , input  logic             pop_i
    , output logic             empty_o
    , output logic             full_o
);

localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CNT_W = $clog2(DEPTH + 1);

logic [WIDTH-1:0] mem_q [DEPTH];
logic [PTR_W-1:0] wr_ptr_q;
logic [PTR_W-1:0] rd_ptr_q;
logic [CNT_W-1:0] count_q;

assign rd_data_o = mem_q[rd_ptr_q];
assign empty_o   = (count_q == '0);
assign full_o    = (count_q == CNT_W'(DEPTH));

// Storage only, written at the tail
always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= wr_data_i;
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
    end else begin
        // Pointers wrap at DEPTH, which need not be a power of two
        if (push_i) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
        if (pop_i)  rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
        case ({push_i, pop_i})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
        endcase
    end
end

// Callers must respect the flags
a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i) full_o |-> !push_i);
a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i) empty_o |-> !pop_i);

endmodule : sync_fifo

// ==== design/input_tracker.sv ====
`include "node_defs.svh"

module input_tracker (
      input  logic                     clk_i
    , input  logic                     rst_n_i
    , input  logic                     trigger_i
    , input  logic [`NODE_IDX_W-1:0]   signal_index_i
    , input  logic                     signal_is_seq_i
    , input  logic                     signal_state_i
    , input  logic                     signal_valid_i
    , input  logic [`NODE_IDX_W-1:0]   lb_index_i
    , input  logic                     lb_state_i
    , input  logic                     lb_valid_i
    , output logic                     core_trigger_o
    , output logic [`NODE_INPUTS-1:0]  core_inputs_o
);

logic [`NODE_INPUTS-1:0] curr_q, curr_d;
logic [`NODE_INPUTS-1:0] next_q, next_d;
logic                    first_q, first_d;
logic                    trig_q, trig_d;

assign core_trigger_o = trig_q;
assign core_inputs_o  = curr_q;

always_comb begin : p_track
    curr_d  = curr_q;
    next_d  = next_q;
    first_d = first_q;
    // Trigger is a single cycle pulse
    trig_d  = 1'b0;

    // External trigger promotes next state to current
    if (trigger_i) begin
        trig_d  = (curr_q != next_q) || first_q;
        curr_d  = next_q;
        first_d = 1'b0;
    end

    if (signal_valid_i) begin
        next_d[signal_index_i] = signal_state_i;
        // Combinational inputs bypass the trigger
        if (!signal_is_seq_i) begin
            curr_d[signal_index_i] = signal_state_i;
            trig_d = trig_d || (curr_q[signal_index_i] != signal_state_i);
        end
    end

    // Loopback always sequential, else the core could chase itself
    if (lb_valid_i) next_d[lb_index_i] = lb_state_i;
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        curr_q  <= '0;
        next_q  <= '0;
        first_q <= 1'b1;
        trig_q  <= 1'b0;
    end else begin
        curr_q  <= curr_d;
        next_q  <= next_d;
        first_q <= first_d;
        trig_q  <= trig_d;
    end
end

endmodule : input_tracker

// ==== design/output_change_detect.sv ====
`include "node_defs.svh"

module output_change_detect (
      input  logic                      clk_i
    , input  logic                      rst_n_i
    , input  logic [`NODE_OUTPUTS-1:0]  core_outputs_i
    , change_if.producer                chg
);

import node_map_pkg::*;

logic [`NODE_OUTPUTS-1:0] last_q, last_d;
logic [`NODE_OUTPUTS-1:0] mask_q, mask_d;
change_req_t              req_q, req_d;
logic                     valid_q, valid_d;

assign chg.req   = req_q;
assign chg.valid = valid_q;

always_comb begin : p_detect
    int   i;
    logic found;

    found   = 1'b0;
    last_d  = last_q;
    mask_d  = mask_q;
    req_d   = req_q;
    valid_d = valid_q;

    // Slot free or being taken this cycle
    if (!valid_q || !chg.full) begin
        // Lowest changed bit wins
        for (i = 0; i < `NODE_OUTPUTS; i++) begin
            if (!found && mask_q[i]) begin
                found       = 1'b1;
                req_d.index = `NODE_IDX_W'(i);
                req_d.state = last_q[i];
                mask_d[i]   = 1'b0;
            end
        end
        valid_d = found;
    end

    // Resample only once every pending bit is out
    // Toggles in between fold into one snapshot
    if (mask_d == '0) begin
        mask_d = core_outputs_i ^ last_q;
        last_d = core_outputs_i;
    end
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        last_q  <= '0;
        mask_q  <= '0;
        valid_q <= 1'b0;
    end else begin
        last_q  <= last_d;
        mask_q  <= mask_d;
        valid_q <= valid_d;
    end
end

always_ff @(posedge clk_i) begin
    req_q <= req_d;
end

endmodule : output_change_detect

// ==== design/fanout_table.sv ====
`include "node_defs.svh"

module fanout_table (
      input  logic                         clk_i
    , input  logic                         rst_n_i
    , input  logic [`NODE_IDX_W-1:0]       map_idx_i
    , input  node_map_pkg::fanout_entry_t  map_entry_i
    , input  logic                         map_valid_i
    , change_if.consumer                   chg
    , fanout_if.source                     fo
);

import node_map_pkg::*;

fanout_entry_t            table_q [`FANOUT_DEPTH];
logic [`FANOUT_AW-1:0]    base_q  [`NODE_OUTPUTS];
logic [`FANOUT_AW-1:0]    final_q [`NODE_OUTPUTS];
// Used entries, one bit wider to spot a full table
logic [`FANOUT_AW:0]      fill_q;
logic [`FANOUT_AW-1:0]    slot;
logic [`NODE_OUTPUTS-1:0] actv_q;

change_req_t              q_head;
logic                     q_empty;
logic                     q_full;
logic                     q_pop;

logic                     walk_q;
logic [`FANOUT_AW-1:0]    walk_ptr_q;
logic [`FANOUT_AW-1:0]    walk_final_q;
logic                     walk_state_q;

assign slot = fill_q[`FANOUT_AW-1:0];

// Change queue
sync_fifo #(
      .DEPTH(2)
    , .WIDTH($bits(change_req_t))
) u_chg_queue (
      .clk_i    (clk_i)
    , .rst_n_i  (rst_n_i)
    , .wr_data_i(chg.req)
    , .push_i   (chg.valid && !q_full)
    , .rd_data_o(q_head)
    , .pop_i    (q_pop)
    , .empty_o  (q_empty)
    , .full_o   (q_full)
);

assign chg.full = q_full;

// Map writes own the table this cycle
assign fo.entry = table_q[walk_ptr_q];
assign fo.state = walk_state_q;
assign fo.valid = walk_q && !fo.stall && !map_valid_i;

// Next change only once the current walk is done
assign q_pop = !walk_q && !q_empty && !map_valid_i;

// Append at the next free slot
always_ff @(posedge clk_i) begin
    if (map_valid_i) begin
        table_q[slot] <= map_entry_i;
        if (!actv_q[map_idx_i]) base_q[map_idx_i] <= slot;
        final_q[map_idx_i] <= slot;
    end
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        fill_q       <= '0;
        actv_q       <= '0;
        walk_q       <= 1'b0;
        walk_ptr_q   <= '0;
        walk_final_q <= '0;
        walk_state_q <= 1'b0;
    end else begin
        if (map_valid_i) begin
            fill_q            <= fill_q + 1'b1;
            actv_q[map_idx_i] <= 1'b1;
        end
        if (fo.valid) begin
            // Last entry of this output issued
            if (walk_ptr_q == walk_final_q) walk_q <= 1'b0;
            else walk_ptr_q <= walk_ptr_q + 1'b1;
        end else if (q_pop && actv_q[q_head.index]) begin
            // Unmapped outputs just fall out of the queue
            walk_q       <= 1'b1;
            walk_ptr_q   <= base_q[q_head.index];
            walk_final_q <= final_q[q_head.index];
            walk_state_q <= q_head.state;
        end
    end
end

a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    map_valid_i |-> (fill_q < (`FANOUT_AW+1)'(`FANOUT_DEPTH)));

endmodule : fanout_table

// ==== design/message_builder.sv ====
`include "node_defs.svh"

module message_builder (
      input  logic                        clk_i
    , input  logic                        rst_n_i
    , input  logic [`NODE_ROW_W-1:0]      node_row_i
    , input  logic [`NODE_COL_W-1:0]      node_col_i
    , input  logic                        msg_ready_i
    , fanout_if.sink                      fo
    , output node_msg_pkg::node_msg_t     msg_data_o
    , output node_msg_pkg::node_dir_t     msg_dir_o
    , output logic                        msg_valid_o
    , output logic [`NODE_IDX_W-1:0]      lb_index_o
    , output logic                        lb_state_o
    , output logic                        lb_valid_o
);

import node_msg_pkg::*;
import node_map_pkg::*;

localparam int HEAD_W = $bits(fanout_entry_t) + 1;

logic [HEAD_W-1:0]      head_word;
fanout_entry_t          head_entry;
logic                   head_state;
logic                   head_lb;
logic                   fifo_empty;
logic                   fifo_full;
logic                   fifo_pop;
logic                   load;

node_msg_t              msg_q, msg_d;
node_dir_t              dir_q, dir_d;
logic                   valid_q;
logic [`NODE_IDX_W-1:0] lb_index_q;
logic                   lb_state_q;
logic                   lb_valid_q;

// Entry plus state
sync_fifo #(
      .DEPTH(4)
    , .WIDTH(HEAD_W)
) u_entry_fifo (
      .clk_i    (clk_i)
    , .rst_n_i  (rst_n_i)
    , .wr_data_i({fo.entry, fo.state})
    , .push_i   (fo.valid)
    , .rd_data_o(head_word)
    , .pop_i    (fifo_pop)
    , .empty_o  (fifo_empty)
    , .full_o   (fifo_full)
);

assign {head_entry, head_state} = head_word;
assign fo.stall = fifo_full;

// Target is this node
assign head_lb  = (head_entry.tgt_row == node_row_i) && (head_entry.tgt_col == node_col_i);
// Output register free or emptying this cycle
assign load     = !fifo_empty && !head_lb && (!valid_q || msg_ready_i);
assign fifo_pop = (!fifo_empty && head_lb) || load;

assign msg_data_o  = msg_q;
assign msg_dir_o   = dir_q;
assign msg_valid_o = valid_q;
assign lb_index_o  = lb_index_q;
assign lb_state_o  = lb_state_q;
assign lb_valid_o  = lb_valid_q;

always_comb begin : p_build
    msg_d = msg_q;
    dir_d = dir_q;
    if (load) begin
        msg_d.raw.header.row     = head_entry.tgt_row;
        msg_d.raw.header.column  = head_entry.tgt_col;
        msg_d.raw.header.command = CMD_SIG_STATE;
        msg_d.raw.payload        = '0;
        msg_d.sig_state.target_index  = head_entry.tgt_idx;
        msg_d.sig_state.target_is_seq = head_entry.tgt_is_seq;
        msg_d.sig_state.state         = head_state;
        // Row first, then column
        if (head_entry.tgt_row < node_row_i)      dir_d = DIR_NORTH;
        else if (head_entry.tgt_row > node_row_i) dir_d = DIR_SOUTH;
        else if (head_entry.tgt_col < node_col_i) dir_d = DIR_WEST;
        else                                      dir_d = DIR_EAST;
    end
end

always_ff @(posedge clk_i) begin
    msg_q      <= msg_d;
    dir_q      <= dir_d;
    lb_index_q <= head_entry.tgt_idx;
    lb_state_q <= head_state;
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        valid_q    <= 1'b0;
        lb_valid_q <= 1'b0;
    end else begin
        if (load) valid_q <= 1'b1;
        else if (msg_ready_i) valid_q <= 1'b0;
        lb_valid_q <= !fifo_empty && head_lb;
    end
end

a_msg_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (msg_valid_o && !msg_ready_i) |=>
        (msg_valid_o && $stable(msg_data_o) && $stable(msg_dir_o)));

endmodule : message_builder

// ==== design/node_ctrl_top.sv ====
`include "node_defs.svh"

module node_ctrl_top (
      input  logic                      clk_i
    , input  logic                      rst_n_i
    // Node address in the mesh
    , input  logic [`NODE_ROW_W-1:0]    node_row_i
    , input  logic [`NODE_COL_W-1:0]    node_col_i
    , input  logic                      trigger_i
    // Output to target mapping
    , input  logic [`NODE_IDX_W-1:0]    map_idx_i
    , input  logic [`NODE_ROW_W-1:0]    map_tgt_row_i
    , input  logic [`NODE_COL_W-1:0]    map_tgt_col_i
    , input  logic [`NODE_IDX_W-1:0]    map_tgt_idx_i
    , input  logic                      map_tgt_seq_i
    , input  logic                      map_valid_i
    // Inbound signal state
    , input  logic [`NODE_IDX_W-1:0]    signal_index_i
    , input  logic                      signal_is_seq_i
    , input  logic                      signal_state_i
    , input  logic                      signal_valid_i
    // Core side
    , output logic                      core_trigger_o
    , output logic [`NODE_INPUTS-1:0]   core_inputs_o
    , input  logic [`NODE_OUTPUTS-1:0]  core_outputs_i
    // Outbound message stream
    , output logic [`MSG_W-1:0]         msg_data_o
    , output node_msg_pkg::node_dir_t   msg_dir_o
    , output logic                      msg_valid_o
    , input  logic                      msg_ready_i
);

logic [`NODE_IDX_W-1:0] lb_index;
logic                   lb_state;
logic                   lb_valid;

change_if chg_if ();
fanout_if fo_if ();

input_tracker u_input_tracker (
      .clk_i          (clk_i)
    , .rst_n_i        (rst_n_i)
    , .trigger_i      (trigger_i)
    , .signal_index_i (signal_index_i)
    , .signal_is_seq_i(signal_is_seq_i)
    , .signal_state_i (signal_state_i)
    , .signal_valid_i (signal_valid_i)
    , .lb_index_i     (lb_index)
    , .lb_state_i     (lb_state)
    , .lb_valid_i     (lb_valid)
    , .core_trigger_o (core_trigger_o)
    , .core_inputs_o  (core_inputs_o)
);

output_change_detect u_change_detect (
      .clk_i         (clk_i)
    , .rst_n_i       (rst_n_i)
    , .core_outputs_i(core_outputs_i)
    , .chg           (chg_if.producer)
);

// Entry packed in fanout_entry_t field order
fanout_table u_fanout_table (
      .clk_i      (clk_i)
    , .rst_n_i    (rst_n_i)
    , .map_idx_i  (map_idx_i)
    , .map_entry_i({map_tgt_row_i, map_tgt_col_i, map_tgt_idx_i, map_tgt_seq_i})
    , .map_valid_i(map_valid_i)
    , .chg        (chg_if.consumer)
    , .fo         (fo_if.source)
);

message_builder u_msg_builder (
      .clk_i      (clk_i)
    , .rst_n_i    (rst_n_i)
    , .node_row_i (node_row_i)
    , .node_col_i (node_col_i)
    , .msg_ready_i(msg_ready_i)
    , .fo         (fo_if.sink)
    , .msg_data_o (msg_data_o)
    , .msg_dir_o  (msg_dir_o)
    , .msg_valid_o(msg_valid_o)
    , .lb_index_o (lb_index)
    , .lb_state_o (lb_state)
    , .lb_valid_o (lb_valid)
);

endmodule : node_ctrl_top

// ==== dv/tb_node_ctrl.sv ====
`include "node_defs.svh"

module tb_node_ctrl;

timeunit 1ns;
timeprecision 100ps;

import node_msg_pkg::*;

localparam int NUM_MAPS = 8;
localparam logic [3:0] SELF_ROW = 4'd5;
localparam logic [3:0] SELF_COL = 4'd5;

// One fan-out mapping plus its expected route
typedef struct packed {
    logic [2:0] src;
    logic [3:0] row;
    logic [3:0] col;
    logic [2:0] idx;
    logic       seq;
    node_dir_t  dir;
} map_row_t;

// Rows of one output kept together since the table appends in load order
// Row 6 targets this node and has no route
map_row_t map_tab [NUM_MAPS] = '{
    '{3'd1, 4'd2,  4'd5,  3'd3, 1'b0, DIR_NORTH},
    '{3'd1, 4'd9,  4'd5,  3'd6, 1'b1, DIR_SOUTH},
    '{3'd1, 4'd5,  4'd1,  3'd2, 1'b0, DIR_WEST},
    '{3'd1, 4'd5,  4'd12, 3'd7, 1'b1, DIR_EAST},
    '{3'd3, 4'd5,  4'd8,  3'd0, 1'b0, DIR_EAST},
    '{3'd3, 4'd0,  4'd0,  3'd4, 1'b1, DIR_NORTH},
    '{3'd4, 4'd5,  4'd5,  3'd6, 1'b0, DIR_NORTH},
    '{3'd6, 4'd14, 4'd3,  3'd1, 1'b1, DIR_SOUTH}
};

logic                     clk_i;
logic                     rst_n_i;
logic                     trigger_i;
logic [`NODE_IDX_W-1:0]   map_idx_i;
logic [`NODE_ROW_W-1:0]   map_tgt_row_i;
logic [`NODE_COL_W-1:0]   map_tgt_col_i;
logic [`NODE_IDX_W-1:0]   map_tgt_idx_i;
logic                     map_tgt_seq_i;
logic                     map_valid_i;
logic [`NODE_IDX_W-1:0]   signal_index_i;
logic                     signal_is_seq_i;
logic                     signal_state_i;
logic                     signal_valid_i;
logic                     core_trigger_o;
logic [`NODE_INPUTS-1:0]  core_inputs_o;
logic [`NODE_OUTPUTS-1:0] core_outputs_i;
logic [`MSG_W-1:0]        msg_data_o;
node_dir_t                msg_dir_o;
logic                     msg_valid_o;
logic                     msg_ready_i;

// Reference model of the core side
logic [`NODE_INPUTS-1:0]  exp_inputs;
logic [`NODE_INPUTS-1:0]  exp_next;
logic [`NODE_OUTPUTS-1:0] out_state;

// Scoreboard queues
int        exp_row_q [$];
logic      exp_state_q [$];
node_msg_t rx_msg_q [$];
node_dir_t rx_dir_q [$];

integer seed = 32'h854a;

node_ctrl_top dut0 (
      .clk_i          (clk_i)
    , .rst_n_i        (rst_n_i)
    , .node_row_i     (SELF_ROW)
    , .node_col_i     (SELF_COL)
    , .trigger_i      (trigger_i)
    , .map_idx_i      (map_idx_i)
    , .map_tgt_row_i  (map_tgt_row_i)
    , .map_tgt_col_i  (map_tgt_col_i)
    , .map_tgt_idx_i  (map_tgt_idx_i)
    , .map_tgt_seq_i  (map_tgt_seq_i)
    , .map_valid_i    (map_valid_i)
    , .signal_index_i (signal_index_i)
    , .signal_is_seq_i(signal_is_seq_i)
    , .signal_state_i (signal_state_i)
    , .signal_valid_i (signal_valid_i)
    , .core_trigger_o (core_trigger_o)
    , .core_inputs_o  (core_inputs_o)
    , .core_outputs_i (core_outputs_i)
    , .msg_data_o     (msg_data_o)
    , .msg_dir_o      (msg_dir_o)
    , .msg_valid_o    (msg_valid_o)
    , .msg_ready_i    (msg_ready_i)
);

initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
end

// Random back-pressure with ready about three cycles in four
initial begin
    msg_ready_i = 1'b0;
    forever begin
        @(posedge clk_i);
        msg_ready_i <= (($random(seed) & 32'sd3) != 0);
    end
end

// Handshake sampled mid-cycle before the transferring edge
always @(negedge clk_i) begin
    if (rst_n_i && msg_valid_o && msg_ready_i) begin
        rx_msg_q.push_back(msg_data_o);
        rx_dir_q.push_back(msg_dir_o);
    end
end

task automatic stop_on_failure();
    $display("Simulation failed");
    $fatal(1, "Stopped at first error");
endtask

task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("Mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
        stop_on_failure();
    end
endtask

task automatic report_timeout(input string what);
    $display("Timeout at %0t ns while waiting for %s", $time, what);
    stop_on_failure();
endtask

function automatic logic is_self(input map_row_t r);
    return (r.row == SELF_ROW) && (r.col == SELF_COL);
endfunction

// Core sees the trigger exactly one cycle later
task automatic pulse_trigger(input logic exp_pulse);
    @(posedge clk_i);
    trigger_i <= 1'b1;
    @(posedge clk_i);
    trigger_i <= 1'b0;
    exp_inputs = exp_next;
    @(negedge clk_i);
    check_value("core_trigger_o after trigger", 32'(core_trigger_o), 32'(exp_pulse));
    check_value("core_inputs_o after trigger", 32'(core_inputs_o), 32'(exp_inputs));
    @(negedge clk_i);
    check_value("core_trigger_o pulse width", 32'(core_trigger_o), 32'(1'b0));
endtask

task automatic signal_update(input int idx, input logic seq, input logic state,
                             input logic exp_pulse);
    @(posedge clk_i);
    signal_index_i  <= 3'(idx);
    signal_is_seq_i <= seq;
    signal_state_i  <= state;
    signal_valid_i  <= 1'b1;
    @(posedge clk_i);
    signal_valid_i  <= 1'b0;
    exp_next[idx] = state;
    // Non-sequential goes straight through
    if (!seq) exp_inputs[idx] = state;
    @(negedge clk_i);
    check_value("core_inputs_o after update", 32'(core_inputs_o), 32'(exp_inputs));
    check_value("core_trigger_o after update", 32'(core_trigger_o), 32'(exp_pulse));
endtask

task automatic load_mappings();
    for (int k = 0; k < NUM_MAPS; k++) begin
        @(posedge clk_i);
        map_idx_i     <= map_tab[k].src;
        map_tgt_row_i <= map_tab[k].row;
        map_tgt_col_i <= map_tab[k].col;
        map_tgt_idx_i <= map_tab[k].idx;
        map_tgt_seq_i <= map_tab[k].seq;
        map_valid_i   <= 1'b1;
    end
    @(posedge clk_i);
    map_valid_i <= 1'b0;
endtask

// Toggle outputs and expect groups in ascending output order
task automatic apply_toggle(input logic [`NODE_OUTPUTS-1:0] mask);
    int        wait_cnt;
    node_msg_t got;
    map_row_t  r;

    exp_row_q.delete();
    exp_state_q.delete();
    rx_msg_q.delete();
    rx_dir_q.delete();
    for (int i = 0; i < `NODE_OUTPUTS; i++) begin
        if (mask[i]) begin
            for (int k = 0; k < NUM_MAPS; k++) begin
                if (32'(map_tab[k].src) == i && !is_self(map_tab[k])) begin
                    exp_row_q.push_back(k);
                    exp_state_q.push_back(!out_state[i]);
                end
            end
        end
    end
    out_state = out_state ^ mask;
    @(posedge clk_i);
    core_outputs_i <= out_state;

    wait_cnt = 0;
    while (rx_msg_q.size() < exp_row_q.size()) begin
        @(negedge clk_i);
        wait_cnt++;
        if (wait_cnt > 400) report_timeout("outbound messages");
    end
    // Quiet window to catch extra messages or loopback
    repeat (40) @(negedge clk_i);
    check_value("message count", 32'(rx_msg_q.size()), 32'(exp_row_q.size()));

    for (int n = 0; n < exp_row_q.size(); n++) begin
        got = rx_msg_q[n];
        r   = map_tab[exp_row_q[n]];
        check_value("header row", 32'(got.sig_state.header.row), 32'(r.row));
        check_value("header column", 32'(got.sig_state.header.column), 32'(r.col));
        check_value("header command", 32'(got.sig_state.header.command), 32'(CMD_SIG_STATE));
        check_value("pad bits", 32'(got.sig_state.pad), 32'(0));
        check_value("target index", 32'(got.sig_state.target_index), 32'(r.idx));
        check_value("target seq flag", 32'(got.sig_state.target_is_seq), 32'(r.seq));
        check_value("signal state", 32'(got.sig_state.state), 32'(exp_state_q[n]));
        check_value("route direction", 32'(rx_dir_q[n]), 32'(r.dir));
    end
endtask

initial begin
    rst_n_i         = 1'b0;
    trigger_i       = 1'b0;
    map_idx_i       = '0;
    map_tgt_row_i   = '0;
    map_tgt_col_i   = '0;
    map_tgt_idx_i   = '0;
    map_tgt_seq_i   = 1'b0;
    map_valid_i     = 1'b0;
    signal_index_i  = '0;
    signal_is_seq_i = 1'b0;
    signal_state_i  = 1'b0;
    signal_valid_i  = 1'b0;
    core_outputs_i  = '0;
    exp_inputs      = '0;
    exp_next        = '0;
    out_state       = '0;

    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_value("core_trigger_o after reset", 32'(core_trigger_o), 32'(1'b0));
    check_value("msg_valid_o after reset", 32'(msg_valid_o), 32'(1'b0));

    // First trigger always fires but an idle one does not
    pulse_trigger(1'b1);
    pulse_trigger(1'b0);

    // Non-sequential then sequential input update
    signal_update(2, 1'b0, 1'b1, 1'b1);
    signal_update(5, 1'b1, 1'b1, 1'b0);
    pulse_trigger(1'b1);

    load_mappings();
    apply_toggle(8'h02);
    // Outputs 1, 3 and 6 in one snapshot
    apply_toggle(8'h4a);

    // Loopback to input 6 shows after the next trigger
    apply_toggle(8'h10);
    exp_next[6] = 1'b1;
    pulse_trigger(1'b1);

    // Unmapped output stays silent
    apply_toggle(8'h04);

    $display("Simulation passed");
    $finish;
end

endmodule : tb_node_ctrl

// ==== flist.f ====
+incdir+design
design/node_msg_pkg.sv
design/node_map_pkg.sv
design/node_ifs.sv
design/sync_fifo.sv
design/input_tracker.sv
design/output_change_detect.sv
design/fanout_table.sv
design/message_builder.sv
design/node_ctrl_top.sv
dv/tb_node_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the node control testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        --top-module tb_node_ctrl -f flist.f -Mdir obj_dir -o sim_node_ctrl; then
    echo "Verilator build failed"
    exit 1
fi

if ! out=$(./obj_dir/sim_node_ctrl 2>&1); then
    printf '%s\n' "$out"
    echo "Simulation run returned an error status"
    exit 1
fi
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1
